// File: include/periph_config.svh
// Widths and the register map assume a 12-bit APB space split into two 256-byte windows

`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// Bus and source sizing
`define PERIPH_ADDR_W       12
`define PERIPH_DATA_W       32
`define PERIPH_NUM_TIMERS   2
`define PERIPH_NUM_EXT      4
`define PERIPH_NUM_SRC      6
`define PERIPH_PRIO_W       3
`define PERIPH_ID_W         3

// Address windows
`define PERIPH_TIMER_BASE   'h000
`define PERIPH_PLIC_BASE    'h100
`define PERIPH_WIN_SIZE     'h100

// Timer registers, repeated every stride
`define PERIPH_TMR_STRIDE   'h10
`define PERIPH_TMR_CTRL     'h0
`define PERIPH_TMR_COUNT    'h4
`define PERIPH_TMR_CMP      'h8
`define PERIPH_TMR_STATUS   'hC

// Interrupt controller registers, PRIO of source i sits at PRIO + 4*i
`define PERIPH_PLIC_PRIO    'h00
`define PERIPH_PLIC_ENABLE  'h20
`define PERIPH_PLIC_THRESH  'h24
`define PERIPH_PLIC_CLAIM   'h28

`endif

// File: design/periph_pkg.sv
// Bus types model APB without pprot and pstrb; all writes are full 32-bit words

`include "periph_config.svh"

package periph_pkg;

    // --------------------
    // APB
    // --------------------
    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`PERIPH_ADDR_W-1:0]  paddr;
        logic [`PERIPH_DATA_W-1:0]  pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`PERIPH_DATA_W-1:0]  prdata;
        logic                       pready;
        logic                       pslverr;
    } apb_resp_t;

    // --------------------
    // Interrupts
    // --------------------

    // Bit i is source id i+1
    typedef logic [`PERIPH_NUM_SRC-1:0] src_vec_t;

    // Claim and complete strobes from the target to the gateway
    typedef struct packed {
        logic                       claim_valid;
        logic [`PERIPH_ID_W-1:0]    claim_id;
        logic                       complete_valid;
        logic [`PERIPH_ID_W-1:0]    complete_id;
    } plic_ctl_t;

endpackage

// File: design/apb_decoder.sv
// Expects a setup phase before every access phase; unmapped addresses get pslverr and zero data

`include "periph_config.svh"

module apb_decoder
    import periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  apb_req_t  req_i,
    output apb_resp_t resp_o,
    output apb_req_t  tmr_req_o,
    input  apb_resp_t tmr_resp_i,
    output apb_req_t  plic_req_o,
    input  apb_resp_t plic_resp_i
);
    localparam int AddrW   = `PERIPH_ADDR_W;
    localparam int WinW    = $clog2(`PERIPH_WIN_SIZE);
    localparam int WinIdxW = AddrW - WinW;

    logic hit_tmr;
    logic hit_plic;
    logic tmr_sel_q;
    logic plic_sel_q;

    // Window index from the upper address bits
    assign hit_tmr  = req_i.paddr[AddrW-1:WinW] ==
                      WinIdxW'(`PERIPH_TIMER_BASE / `PERIPH_WIN_SIZE);
    assign hit_plic = req_i.paddr[AddrW-1:WinW] ==
                      WinIdxW'(`PERIPH_PLIC_BASE / `PERIPH_WIN_SIZE);

    always_comb begin
        tmr_req_o       = req_i;
        tmr_req_o.psel  = req_i.psel && hit_tmr;
        plic_req_o      = req_i;
        plic_req_o.psel = req_i.psel && hit_plic;
    end

    // Slave selection latched in setup, used for the response in access
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tmr_sel_q  <= 1'b0;
            plic_sel_q <= 1'b0;
        end else if (req_i.psel && !req_i.penable) begin
            tmr_sel_q  <= hit_tmr;
            plic_sel_q <= hit_plic;
        end else if (!req_i.psel) begin
            tmr_sel_q  <= 1'b0;
            plic_sel_q <= 1'b0;
        end
    end

    always_comb begin
        resp_o        = '0;
        resp_o.pready = 1'b1;
        if (tmr_sel_q) begin
            resp_o = tmr_resp_i;
        end else if (plic_sel_q) begin
            resp_o = plic_resp_i;
        end else begin
            resp_o.pslverr = req_i.psel && req_i.penable;
        end
    end

endmodule

// File: design/apb_timer.sv
// Timers count only while CTRL bit0 is set; a bus write to COUNT overrides the increment

`include "periph_config.svh"

module apb_timer
    import periph_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  apb_req_t                      req_i,
    output apb_resp_t                     resp_o,
    output logic [`PERIPH_NUM_TIMERS-1:0] match_o
);
    localparam int NumTmr  = `PERIPH_NUM_TIMERS;
    localparam int DataW   = `PERIPH_DATA_W;
    localparam int WinW    = $clog2(`PERIPH_WIN_SIZE);
    localparam int StrideW = $clog2(`PERIPH_TMR_STRIDE);

    logic [WinW-1:0]         off;
    logic [WinW-StrideW-1:0] tmr_idx;
    logic [StrideW-1:0]      reg_off;
    logic                    access;
    logic                    reg_valid;
    logic                    wr_en;
    logic [NumTmr-1:0]       en_q;
    logic [NumTmr-1:0]       flag_q;
    logic [NumTmr-1:0]       hit_cmp;
    logic [DataW-1:0]        count_q [NumTmr];
    logic [DataW-1:0]        cmp_q   [NumTmr];

    assign off       = req_i.paddr[WinW-1:0];
    assign tmr_idx   = off[WinW-1:StrideW];
    assign reg_off   = off[StrideW-1:0];
    assign access    = req_i.psel && req_i.penable;
    assign reg_valid = (int'(tmr_idx) < NumTmr) && (reg_off[1:0] == 2'b00);
    assign wr_en     = access && req_i.pwrite && reg_valid;

    always_comb begin
        for (int i = 0; i < NumTmr; i++) begin
            hit_cmp[i] = en_q[i] && (count_q[i] == cmp_q[i]);
        end
    end

    // --------------------
    // Counters and flags
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en_q   <= '0;
            flag_q <= '0;
            for (int i = 0; i < NumTmr; i++) begin
                count_q[i] <= '0;
                cmp_q[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < NumTmr; i++) begin
                if (hit_cmp[i]) begin
                    count_q[i] <= '0;
                    flag_q[i]  <= 1'b1;
                end else if (en_q[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;
                end
                // Bus write last, so clearing the flag beats a match
                if (wr_en && int'(tmr_idx) == i) begin
                    case (reg_off)
                        StrideW'(`PERIPH_TMR_CTRL):   en_q[i]    <= req_i.pwdata[0];
                        StrideW'(`PERIPH_TMR_COUNT):  count_q[i] <= req_i.pwdata;
                        StrideW'(`PERIPH_TMR_CMP):    cmp_q[i]   <= req_i.pwdata;
                        StrideW'(`PERIPH_TMR_STATUS): begin
                            if (req_i.pwdata[0]) begin
                                flag_q[i] <= 1'b0;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // --------------------
    // Read path
    // --------------------
    always_comb begin
        resp_o         = '0;
        resp_o.pready  = 1'b1;
        resp_o.pslverr = access && !reg_valid;
        if (access && !req_i.pwrite && reg_valid) begin
            for (int i = 0; i < NumTmr; i++) begin
                if (int'(tmr_idx) == i) begin
                    case (reg_off)
                        StrideW'(`PERIPH_TMR_CTRL):   resp_o.prdata = DataW'(en_q[i]);
                        StrideW'(`PERIPH_TMR_COUNT):  resp_o.prdata = count_q[i];
                        StrideW'(`PERIPH_TMR_CMP):    resp_o.prdata = cmp_q[i];
                        StrideW'(`PERIPH_TMR_STATUS): resp_o.prdata = DataW'(flag_q[i]);
                        default:                      resp_o.prdata = '0;
                    endcase
                end
            end
        end
    end

    assign match_o = flag_q;

endmodule

// File: design/plic_gateway.sv
// Level sources only; a source re-pends after completion only if it is still high

`include "periph_config.svh"

module plic_gateway
    import periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  src_vec_t  src_i,
    input  plic_ctl_t ctl_i,
    output src_vec_t  pending_o
);
    localparam int NumSrc = `PERIPH_NUM_SRC;
    localparam int IdW    = `PERIPH_ID_W;

    src_vec_t pending_q;
    src_vec_t pending_d;
    src_vec_t in_service_q;
    src_vec_t in_service_d;
    src_vec_t claim_hit;
    src_vec_t complete_hit;

    // Id 0 never matches, so a claim of nothing is harmless
    always_comb begin
        for (int i = 0; i < NumSrc; i++) begin
            claim_hit[i]    = ctl_i.claim_valid && (ctl_i.claim_id == IdW'(i + 1));
            complete_hit[i] = ctl_i.complete_valid && (ctl_i.complete_id == IdW'(i + 1));
        end
    end

    always_comb begin
        for (int i = 0; i < NumSrc; i++) begin
            // Capture only when idle
            pending_d[i] = pending_q[i] || (src_i[i] && !in_service_q[i]);
            if (claim_hit[i]) begin
                pending_d[i] = 1'b0;
            end
            in_service_d[i] = (in_service_q[i] || claim_hit[i]) && !complete_hit[i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            pending_q    <= pending_d;
            in_service_q <= in_service_d;
        end
    end

    assign pending_o = pending_q;

endmodule

// File: design/plic_target.sv
// Single target; priority 0 disables a source and ties go to the lowest id

`include "periph_config.svh"

module plic_target
    import periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  apb_req_t  req_i,
    output apb_resp_t resp_o,
    input  src_vec_t  pending_i,
    output plic_ctl_t ctl_o,
    output logic      irq_o
);
    localparam int NumSrc = `PERIPH_NUM_SRC;
    localparam int PrioW  = `PERIPH_PRIO_W;
    localparam int IdW    = `PERIPH_ID_W;
    localparam int DataW  = `PERIPH_DATA_W;
    localparam int WinW   = $clog2(`PERIPH_WIN_SIZE);

    logic [WinW-1:0]  off;
    src_vec_t         prio_sel;
    logic             is_enable;
    logic             is_thresh;
    logic             is_claim;
    logic             access;
    logic             reg_valid;
    logic             wr_en;
    logic             rd_en;
    logic [PrioW-1:0] prio_q [NumSrc];
    src_vec_t         enable_q;
    logic [PrioW-1:0] threshold_q;
    logic [IdW-1:0]   best_id_d;
    logic [IdW-1:0]   best_id_q;
    logic [PrioW-1:0] best_prio_d;
    logic [PrioW-1:0] best_prio_q;

    assign off = req_i.paddr[WinW-1:0];

    always_comb begin
        for (int i = 0; i < NumSrc; i++) begin
            prio_sel[i] = off == WinW'(`PERIPH_PLIC_PRIO + 4 * (i + 1));
        end
    end

    assign is_enable = off == WinW'(`PERIPH_PLIC_ENABLE);
    assign is_thresh = off == WinW'(`PERIPH_PLIC_THRESH);
    assign is_claim  = off == WinW'(`PERIPH_PLIC_CLAIM);
    assign access    = req_i.psel && req_i.penable;
    assign reg_valid = (|prio_sel) || is_enable || is_thresh || is_claim;
    assign wr_en     = access && req_i.pwrite && reg_valid;
    assign rd_en     = access && !req_i.pwrite && reg_valid;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            enable_q    <= '0;
            threshold_q <= '0;
            for (int i = 0; i < NumSrc; i++) begin
                prio_q[i] <= '0;
            end
        end else if (wr_en) begin
            for (int i = 0; i < NumSrc; i++) begin
                if (prio_sel[i]) begin
                    prio_q[i] <= req_i.pwdata[PrioW-1:0];
                end
            end
            if (is_enable) begin
                enable_q <= req_i.pwdata[NumSrc-1:0];
            end
            if (is_thresh) begin
                threshold_q <= req_i.pwdata[PrioW-1:0];
            end
        end
    end

    // --------------------
    // Best source
    // --------------------
    always_comb begin
        best_id_d   = '0;
        best_prio_d = '0;
        // Strict compare in ascending order keeps the lower id on a tie
        for (int i = 0; i < NumSrc; i++) begin
            if (pending_i[i] && enable_q[i] && (prio_q[i] > best_prio_d)) begin
                best_id_d   = IdW'(i + 1);
                best_prio_d = prio_q[i];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            best_id_q   <= '0;
            best_prio_q <= '0;
        end else begin
            best_id_q   <= best_id_d;
            best_prio_q <= best_prio_d;
        end
    end

    assign irq_o = best_prio_q > threshold_q;

    // Claim on read, complete on write of the same register
    always_comb begin
        ctl_o.claim_valid    = rd_en && is_claim;
        ctl_o.claim_id       = best_id_q;
        ctl_o.complete_valid = wr_en && is_claim;
        ctl_o.complete_id    = req_i.pwdata[IdW-1:0];
    end

    always_comb begin
        resp_o         = '0;
        resp_o.pready  = 1'b1;
        resp_o.pslverr = access && !reg_valid;
        if (rd_en) begin
            for (int i = 0; i < NumSrc; i++) begin
                if (prio_sel[i]) begin
                    resp_o.prdata = DataW'(prio_q[i]);
                end
            end
            if (is_enable) begin
                resp_o.prdata = DataW'(enable_q);
            end
            if (is_thresh) begin
                resp_o.prdata = DataW'(threshold_q);
            end
            if (is_claim) begin
                resp_o.prdata = DataW'(best_id_q);
            end
        end
    end

endmodule

// File: design/periph_top.sv
// APB slave with no wait states; sources 1-2 are timer flags, 3-6 are level inputs ext_irq_i

`include "periph_config.svh"

module periph_top
    import periph_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  apb_req_t                   apb_req_i,
    output apb_resp_t                  apb_resp_o,
    input  logic [`PERIPH_NUM_EXT-1:0] ext_irq_i,
    output logic                       irq_o
);
    apb_req_t                       tmr_req;
    apb_resp_t                      tmr_resp;
    apb_req_t                       plic_req;
    apb_resp_t                      plic_resp;
    logic [`PERIPH_NUM_TIMERS-1:0]  tmr_match;
    src_vec_t                       src_vec;
    src_vec_t                       pending;
    plic_ctl_t                      plic_ctl;

    // Timer flags take the low ids
    assign src_vec = {ext_irq_i, tmr_match};

    apb_decoder i_decoder (
        .clk_i       ( clk_i      ),
        .rst_i       ( rst_i      ),
        .req_i       ( apb_req_i  ),
        .resp_o      ( apb_resp_o ),
        .tmr_req_o   ( tmr_req    ),
        .tmr_resp_i  ( tmr_resp   ),
        .plic_req_o  ( plic_req   ),
        .plic_resp_i ( plic_resp  )
    );

    apb_timer i_timer (
        .clk_i   ( clk_i     ),
        .rst_i   ( rst_i     ),
        .req_i   ( tmr_req   ),
        .resp_o  ( tmr_resp  ),
        .match_o ( tmr_match )
    );

    plic_gateway i_gateway (
        .clk_i     ( clk_i    ),
        .rst_i     ( rst_i    ),
        .src_i     ( src_vec  ),
        .ctl_i     ( plic_ctl ),
        .pending_o ( pending  )
    );

    plic_target i_target (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .req_i     ( plic_req  ),
        .resp_o    ( plic_resp ),
        .pending_i ( pending   ),
        .ctl_o     ( plic_ctl  ),
        .irq_o     ( irq_o     )
    );

endmodule

// File: bench/periph_assertions.sv
// Properties assume an APB slave with no wait states; bound into every periph_top instance

module periph_assertions
    import periph_pkg::*;
(
    input logic      clk_i,
    input logic      rst_i,
    input apb_req_t  apb_req_i,
    input apb_resp_t apb_resp_i,
    input logic      irq_i
);
    int assert_errors = 0;

    // Errors only in the access phase
    pslverr_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
        apb_resp_i.pslverr |-> (apb_req_i.psel && apb_req_i.penable))
    else begin
        $error("pslverr high outside an APB access phase");
        assert_errors++;
    end

    pslverr_zero_data: assert property (@(posedge clk_i) disable iff (rst_i)
        apb_resp_i.pslverr |-> (apb_resp_i.prdata == '0))
    else begin
        $error("prdata not zero on an error response");
        assert_errors++;
    end

    irq_low_after_reset: assert property (@(posedge clk_i) rst_i |=> !irq_i)
    else begin
        $error("irq_o high in the cycle after reset");
        assert_errors++;
    end

endmodule

bind periph_top periph_assertions i_assertions (
    .clk_i      ( clk_i      ),
    .rst_i      ( rst_i      ),
    .apb_req_i  ( apb_req_i  ),
    .apb_resp_i ( apb_resp_o ),
    .irq_i      ( irq_o      )
);

// File: bench/periph_checker.sv
// Samples the DUT on the rising edge of each armed check; expectations come from the stimulus table

`include "periph_config.svh"

module periph_checker
    import periph_pkg::*;
(
    input  logic                      clk_i,
    input  apb_resp_t                 resp_i,
    input  logic                      irq_i,
    input  logic                      chk_valid_i,
    input  logic                      chk_read_i,
    input  logic                      chk_irq_i,
    input  int                        chk_idx_i,
    input  logic [`PERIPH_DATA_W-1:0] exp_data_i,
    input  logic                      exp_err_i,
    input  logic                      done_i,
    output int                        test_count_o,
    output int                        error_count_o
);
    int   tests  = 0;
    int   errors = 0;
    logic ok;

    always @(posedge clk_i) begin
        if (chk_valid_i) begin
            ok = 1'b1;
            if (chk_irq_i) begin
                if (irq_i !== exp_data_i[0]) begin
                    $display("irq_o did not reach expected level %0b by time %0t",
                             exp_data_i[0], $time);
                    ok = 1'b0;
                end
            end else begin
                // No wait states, so every access phase completes
                if (resp_i.pready !== 1'b1) begin
                    $display("Mismatch at %0t: pready expected 1, got %0b",
                             $time, resp_i.pready);
                    ok = 1'b0;
                end
                if (resp_i.pslverr !== exp_err_i) begin
                    $display("Mismatch at %0t: pslverr expected %0b, got %0b",
                             $time, exp_err_i, resp_i.pslverr);
                    ok = 1'b0;
                end
                if (chk_read_i && resp_i.prdata !== exp_data_i) begin
                    $display("Mismatch at %0t: prdata expected 0x%08h, got 0x%08h",
                             $time, exp_data_i, resp_i.prdata);
                    ok = 1'b0;
                end
            end
            tests = tests + 1;
            if (!ok) begin
                errors = errors + 1;
            end
            $display("Test %0d %s at %0t", chk_idx_i, ok ? "passed" : "failed", $time);
        end
    end

    always @(posedge done_i) begin
        $display("Checks run: %0d, failed: %0d", tests, errors);
    end

    assign test_count_o  = tests;
    assign error_count_o = errors;

endmodule

// File: bench/periph_tb.sv
// Stimulus comes from a fixed table; irq waits give up after 32 cycles, the run after 40 per step

`include "periph_config.svh"

module periph_tb
    import periph_pkg::*;
();
    localparam logic [1:0] OpWrite = 2'd0;
    localparam logic [1:0] OpRead  = 2'd1;
    localparam logic [1:0] OpExt   = 2'd2;
    localparam logic [1:0] OpIrq   = 2'd3;
    localparam int IrqPollMax    = 32;
    localparam int CyclesPerStep = 40;

    typedef struct packed {
        logic [1:0]                op;
        logic [`PERIPH_ADDR_W-1:0] addr;
        logic [`PERIPH_DATA_W-1:0] data;
        logic [`PERIPH_DATA_W-1:0] exp_data;
        logic                      exp_err;
    } step_t;

    logic                       clk;
    logic                       rst;
    apb_req_t                   apb_req;
    apb_resp_t                  apb_resp;
    logic [`PERIPH_NUM_EXT-1:0] ext_irq;
    logic                       irq;
    logic                       chk_valid;
    logic                       chk_read;
    logic                       chk_irq;
    logic                       chk_err;
    logic [`PERIPH_DATA_W-1:0]  chk_data;
    logic                       done;
    int                         chk_idx;
    int                         test_count;
    int                         error_count;
    int                         num_checks = 0;
    int                         cycles     = 0;
    int                         max_cycles = 0;
    step_t                      steps[$];

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (max_cycles > 0 && cycles >= max_cycles) begin
            $display("Timeout after %0d cycles, the stimulus did not finish", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    periph_top DUT (
        .clk_i      ( clk      ),
        .rst_i      ( rst      ),
        .apb_req_i  ( apb_req  ),
        .apb_resp_o ( apb_resp ),
        .ext_irq_i  ( ext_irq  ),
        .irq_o      ( irq      )
    );

    periph_checker i_checker (
        .clk_i         ( clk         ),
        .resp_i        ( apb_resp    ),
        .irq_i         ( irq         ),
        .chk_valid_i   ( chk_valid   ),
        .chk_read_i    ( chk_read    ),
        .chk_irq_i     ( chk_irq     ),
        .chk_idx_i     ( chk_idx     ),
        .exp_data_i    ( chk_data    ),
        .exp_err_i     ( chk_err     ),
        .done_i        ( done        ),
        .test_count_o  ( test_count  ),
        .error_count_o ( error_count )
    );

    task automatic add_step(input logic [1:0] op, input logic [`PERIPH_ADDR_W-1:0] addr,
                            input logic [`PERIPH_DATA_W-1:0] data,
                            input logic [`PERIPH_DATA_W-1:0] exp_data, input logic exp_err);
        step_t s;
        s.op       = op;
        s.addr     = addr;
        s.data     = data;
        s.exp_data = exp_data;
        s.exp_err  = exp_err;
        steps.push_back(s);
    endtask

    task automatic arm_check(input int idx, input logic is_read, input logic is_irq,
                             input logic [`PERIPH_DATA_W-1:0] exp_data, input logic exp_err);
        chk_valid = 1'b1;
        chk_idx   = idx;
        chk_read  = is_read;
        chk_irq   = is_irq;
        chk_data  = exp_data;
        chk_err   = exp_err;
    endtask

    // --------------------
    // One table entry, starting and ending on a falling edge
    task automatic run_step(input step_t s, input int idx);
        int polls;
        polls = 0;
        case (s.op)
            OpWrite, OpRead: begin
                apb_req.psel    = 1'b1;
                apb_req.penable = 1'b0;
                apb_req.pwrite  = (s.op == OpWrite);
                apb_req.paddr   = s.addr;
                apb_req.pwdata  = s.data;
                @(negedge clk);
                apb_req.penable = 1'b1;
                arm_check(idx, s.op == OpRead, 1'b0, s.exp_data, s.exp_err);
                @(negedge clk);
                apb_req   = '0;
                chk_valid = 1'b0;
            end
            OpExt: begin
                ext_irq = s.data[`PERIPH_NUM_EXT-1:0];
                @(negedge clk);
            end
            default: begin
                while (irq !== s.exp_data[0] && polls < IrqPollMax) begin
                    @(negedge clk);
                    polls++;
                end
                arm_check(idx, 1'b0, 1'b1, s.exp_data, 1'b0);
                @(negedge clk);
                chk_valid = 1'b0;
            end
        endcase
    endtask

    initial begin
        rst       = 1'b1;
        apb_req   = '0;
        ext_irq   = '0;
        chk_valid = 1'b0;
        chk_read  = 1'b0;
        chk_irq   = 1'b0;
        chk_err   = 1'b0;
        chk_data  = '0;
        chk_idx   = 0;
        done      = 1'b0;

        // Register readback, PRIO keeps only 3 bits
        add_step(OpWrite, 12'h008, 32'h1234_5678, 32'h0, 1'b0);
        add_step(OpRead,  12'h008, 32'h0, 32'h1234_5678, 1'b0);
        add_step(OpWrite, 12'h014, 32'h42, 32'h0, 1'b0);
        add_step(OpRead,  12'h014, 32'h0, 32'h42, 1'b0);
        add_step(OpWrite, 12'h118, 32'hF, 32'h0, 1'b0);
        add_step(OpRead,  12'h118, 32'h0, 32'h7, 1'b0);
        add_step(OpWrite, 12'h120, 32'h2A, 32'h0, 1'b0);
        add_step(OpRead,  12'h120, 32'h0, 32'h2A, 1'b0);
        add_step(OpWrite, 12'h124, 32'h4, 32'h0, 1'b0);
        add_step(OpRead,  12'h124, 32'h0, 32'h4, 1'b0);
        // Unmapped address and window holes
        add_step(OpRead,  12'h300, 32'h0, 32'h0, 1'b1);
        add_step(OpWrite, 12'h300, 32'hFF, 32'h0, 1'b1);
        add_step(OpRead,  12'h0F0, 32'h0, 32'h0, 1'b1);
        // Timer 0 match as source 1
        add_step(OpWrite, 12'h008, 32'h5, 32'h0, 1'b0);
        add_step(OpWrite, 12'h104, 32'h3, 32'h0, 1'b0);
        add_step(OpWrite, 12'h120, 32'h1, 32'h0, 1'b0);
        add_step(OpWrite, 12'h124, 32'h0, 32'h0, 1'b0);
        add_step(OpWrite, 12'h000, 32'h1, 32'h0, 1'b0);
        add_step(OpIrq,   12'h000, 32'h0, 32'h1, 1'b0);
        add_step(OpRead,  12'h128, 32'h0, 32'h1, 1'b0);
        add_step(OpWrite, 12'h000, 32'h0, 32'h0, 1'b0);
        add_step(OpWrite, 12'h00C, 32'h1, 32'h0, 1'b0);
        add_step(OpWrite, 12'h128, 32'h1, 32'h0, 1'b0);
        add_step(OpIrq,   12'h000, 32'h0, 32'h0, 1'b0);
        add_step(OpRead,  12'h128, 32'h0, 32'h0, 1'b0);
        // Priority order, ids 3 and 5
        add_step(OpWrite, 12'h10C, 32'h2, 32'h0, 1'b0);
        add_step(OpWrite, 12'h114, 32'h6, 32'h0, 1'b0);
        add_step(OpWrite, 12'h120, 32'h14, 32'h0, 1'b0);
        add_step(OpExt,   12'h000, 32'h5, 32'h0, 1'b0);
        add_step(OpIrq,   12'h000, 32'h0, 32'h1, 1'b0);
        add_step(OpRead,  12'h128, 32'h0, 32'h5, 1'b0);
        add_step(OpExt,   12'h000, 32'h1, 32'h0, 1'b0);
        add_step(OpWrite, 12'h128, 32'h5, 32'h0, 1'b0);
        add_step(OpRead,  12'h128, 32'h0, 32'h3, 1'b0);
        add_step(OpExt,   12'h000, 32'h0, 32'h0, 1'b0);
        add_step(OpWrite, 12'h128, 32'h3, 32'h0, 1'b0);
        // Equal priorities go to the lower id
        add_step(OpWrite, 12'h114, 32'h2, 32'h0, 1'b0);
        add_step(OpExt,   12'h000, 32'h5, 32'h0, 1'b0);
        add_step(OpIrq,   12'h000, 32'h0, 32'h1, 1'b0);
        add_step(OpRead,  12'h128, 32'h0, 32'h3, 1'b0);
        add_step(OpExt,   12'h000, 32'h0, 32'h0, 1'b0);
        add_step(OpWrite, 12'h128, 32'h3, 32'h0, 1'b0);
        add_step(OpRead,  12'h128, 32'h0, 32'h5, 1'b0);
        add_step(OpWrite, 12'h128, 32'h5, 32'h0, 1'b0);
        add_step(OpIrq,   12'h000, 32'h0, 32'h0, 1'b0);
        // Threshold masking, claim still sees id 3
        add_step(OpWrite, 12'h124, 32'h2, 32'h0, 1'b0);
        add_step(OpWrite, 12'h120, 32'h4, 32'h0, 1'b0);
        add_step(OpExt,   12'h000, 32'h1, 32'h0, 1'b0);
        add_step(OpRead,  12'h124, 32'h0, 32'h2, 1'b0);
        add_step(OpIrq,   12'h000, 32'h0, 32'h0, 1'b0);
        add_step(OpRead,  12'h128, 32'h0, 32'h3, 1'b0);
        add_step(OpWrite, 12'h128, 32'h3, 32'h0, 1'b0);
        add_step(OpWrite, 12'h124, 32'h1, 32'h0, 1'b0);
        add_step(OpIrq,   12'h000, 32'h0, 32'h1, 1'b0);
        // In service blocks re-pend while input stays high
        add_step(OpRead,  12'h128, 32'h0, 32'h3, 1'b0);
        add_step(OpIrq,   12'h000, 32'h0, 32'h0, 1'b0);
        add_step(OpRead,  12'h128, 32'h0, 32'h0, 1'b0);
        add_step(OpWrite, 12'h128, 32'h3, 32'h0, 1'b0);
        add_step(OpIrq,   12'h000, 32'h0, 32'h1, 1'b0);
        add_step(OpExt,   12'h000, 32'h0, 32'h0, 1'b0);
        add_step(OpRead,  12'h128, 32'h0, 32'h3, 1'b0);
        add_step(OpWrite, 12'h128, 32'h3, 32'h0, 1'b0);
        add_step(OpIrq,   12'h000, 32'h0, 32'h0, 1'b0);

        max_cycles = steps.size() * CyclesPerStep;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        foreach (steps[i]) begin
            if (steps[i].op != OpExt) begin
                num_checks++;
            end
            run_step(steps[i], i + 1);
        end

        done = 1'b1;
        @(negedge clk);
        if (error_count == 0 && test_count == num_checks &&
            DUT.i_assertions.assert_errors == 0) begin
            $display("Regression passed");
        end else begin
            if (test_count != num_checks) begin
                $display("Only %0d of %0d checks were run", test_count, num_checks);
            end
            if (DUT.i_assertions.assert_errors != 0) begin
                $display("%0d assertion failures", DUT.i_assertions.assert_errors);
            end
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+include
design/periph_pkg.sv
design/apb_decoder.sv
design/apb_timer.sv
design/plic_gateway.sv
design/plic_target.sv
design/periph_top.sv
bench/periph_assertions.sv
bench/periph_checker.sv
bench/periph_tb.sv

// File: Makefile
# Verilator build and regression run for the APB peripheral subsystem

VERILATOR ?= verilator
TOP       ?= periph_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Regression failed

SRCS := $(wildcard include/*.svh design/*.sv bench/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
